// ==== bench/mmu_top_tb.sv ====
// Testbench for the Sv32 translation unit with a reference TLB model and response checks
`timescale 1ns/10ps

module mmu_top_tb;

    localparam int ENTRIES_W = 4;
    localparam int WAYS      = 3;
    localparam int SETS      = 2 ** ENTRIES_W;

    typedef struct packed {
        logic [2:0]           test_id;
        tlb_pkg::xlate_resp_t resp;
    } expect_t;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    tlb_pkg::xlate_req_t  req;
    logic                 fill_valid;
    tlb_pkg::tlb_fill_t   fill;
    logic                 flush;
    logic                 resp_valid;
    tlb_pkg::xlate_resp_t resp;

    // Reference TLB with one round-robin pointer shared by all sets
    logic [tlb_pkg::vpn_w-1:0] model_vpn   [SETS][WAYS];
    logic [tlb_pkg::ppn_w-1:0] model_ppn   [SETS][WAYS];
    tlb_pkg::pte_flags_t       model_flags [SETS][WAYS];
    logic                      model_valid [SETS][WAYS];
    int                        model_rr;

    expect_t                   exp_q [$];
    logic [tlb_pkg::vpn_w-1:0] filled [$];
    logic [tlb_pkg::vpn_w-1:0] rr_vpn [WAYS+1];
    expect_t                   exp_head = '0;
    tlb_pkg::xlate_resp_t      got_resp = '0;
    logic                      chk_valid = 1'b0;
    logic                      orphan = 1'b0;
    logic [2:0]                cur_test;
    logic [31:0]               rnd;
    integer                    seed = 36308;
    int                        value_errors = 0;
    int                        proto_errors = 0;
    int                        responses = 0;

    mmu_top #(
        .ENTRIES_W (ENTRIES_W),
        .WAYS      (WAYS)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .fill_valid (fill_valid),
        .fill       (fill),
        .flush      (flush),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #200000;
        $display("Simulation watchdog expired");
        $display("Some tests failed");
        $finish;
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "reset_miss";
            3'd2: return "fill_hit";
            3'd3: return "permissions";
            3'd4: return "round_robin";
            3'd5: return "flush";
            3'd6: return "back_to_back";
            default: return "unknown";
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic model_has(input logic [tlb_pkg::vpn_w-1:0] v);
        logic found;
        found = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[v[ENTRIES_W-1:0]][w] && model_vpn[v[ENTRIES_W-1:0]][w] == v) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Expected response from the Sv32 rules applied to the model contents
    function automatic tlb_pkg::xlate_resp_t model_expect(input tlb_pkg::xlate_req_t r);
        tlb_pkg::xlate_resp_t res;
        tlb_pkg::pte_flags_t  f;
        logic [ENTRIES_W-1:0] idx;
        logic                 bad;
        int                   hw;
        idx = r.vaddr[12+ENTRIES_W-1:12];
        hw = -1;
        res = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[idx][w] && model_vpn[idx][w] == r.vaddr[31:12]) begin
                hw = w;
            end
        end
        if (hw >= 0) begin
            f = model_flags[idx][hw];
            bad = !f.accessed || (f.user != r.user);
            if (r.access == tlb_pkg::acc_load && !f.read) bad = 1'b1;
            if (r.access == tlb_pkg::acc_store && !(f.write && f.dirty)) bad = 1'b1;
            if (r.access == tlb_pkg::acc_fetch && !f.execute) bad = 1'b1;
            res.hit = 1'b1;
            res.fault = bad;
            if (!bad) begin
                res.paddr = {model_ppn[idx][hw], r.vaddr[11:0]};
            end
        end
        return res;
    endfunction

    // New page number not present in the model, optionally forced into one set
    function automatic logic [tlb_pkg::vpn_w-1:0] fresh_vpn(input int set_sel);
        logic [31:0]               r;
        logic [tlb_pkg::vpn_w-1:0] v;
        v = '0;
        for (int tries = 0; tries < 16; tries++) begin
            r = $random(seed);
            v = r[tlb_pkg::vpn_w-1:0];
            if (set_sel >= 0) v[ENTRIES_W-1:0] = set_sel[ENTRIES_W-1:0];
            if (!model_has(v)) break;
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    task automatic drive_fill(input logic [tlb_pkg::vpn_w-1:0] v, input tlb_pkg::pte_flags_t f);
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        req_valid = 1'b0;
        flush = 1'b0;
        fill_valid = 1'b1;
        fill.vpn = v;
        fill.ppn = r[tlb_pkg::ppn_w-1:0];
        fill.flags = f;
        model_vpn[v[ENTRIES_W-1:0]][model_rr] = v;
        model_ppn[v[ENTRIES_W-1:0]][model_rr] = r[tlb_pkg::ppn_w-1:0];
        model_flags[v[ENTRIES_W-1:0]][model_rr] = f;
        model_valid[v[ENTRIES_W-1:0]][model_rr] = f.valid;
        model_rr = (model_rr == WAYS - 1) ? 0 : model_rr + 1;
        filled.push_back(v);
    endtask

    task automatic drive_lookup(input logic [tlb_pkg::vpn_w-1:0] v, input tlb_pkg::access_e acc,
                                input logic user);
        expect_t     e;
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        fill_valid = 1'b0;
        flush = 1'b0;
        req_valid = 1'b1;
        req.vaddr = {v, r[11:0]};
        req.access = acc;
        req.user = user;
        e.test_id = cur_test;
        e.resp = model_expect(req);
        exp_q.push_back(e);
    endtask

    task automatic drive_flush;
        @(negedge clk);
        req_valid = 1'b0;
        fill_valid = 1'b0;
        flush = 1'b1;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        model_rr = 0;
    endtask

    task automatic drain_responses;
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b0;
        fill_valid = 1'b0;
        flush = 1'b0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out waiting for %0d responses", exp_q.size());
            proto_errors++;
            exp_q.delete();
        end
        // Let the last popped response reach its check
        repeat (2) @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // Response capture and checks
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        chk_valid = 1'b0;
        orphan = 1'b0;
        if (rst_n && resp_valid) begin
            if (exp_q.size() == 0) begin
                orphan = 1'b1;
            end else begin
                exp_head = exp_q.pop_front();
                got_resp = resp;
                chk_valid = 1'b1;
                responses++;
            end
        end
    end

    a_latency : assert property (
        @(posedge clk) disable iff (!rst_n) req_valid |-> ##2 resp_valid
    ) else begin
        $display("No response two cycles after a request");
        proto_errors++;
    end

    a_no_orphan : assert property (
        @(posedge clk) disable iff (!rst_n) !orphan
    ) else begin
        $display("Response arrived with no request pending");
        proto_errors++;
    end

    a_resp_match : assert property (
        @(posedge clk) disable iff (!rst_n) chk_valid |-> (got_resp == exp_head.resp)
    ) else begin
        $display("Fail %s: expected %h, actual %h", test_name(exp_head.test_id),
                 exp_head.resp, got_resp);
        value_errors++;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        fill_valid = 1'b0;
        fill = '0;
        flush = 1'b0;
        model_rr = 0;
        cur_test = 3'd0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        cur_test = 3'd1;
        for (int i = 0; i < 4; i++) begin
            drive_lookup(fresh_vpn(-1), tlb_pkg::acc_load, 1'b0);
        end
        drain_responses();

        // Full supervisor permissions, random access kinds
        cur_test = 3'd2;
        rr_vpn[0] = fresh_vpn(-1);
        drive_fill(rr_vpn[0], tlb_pkg::pte_flags_t'(8'hCF));
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            drive_lookup(rr_vpn[0], tlb_pkg::access_e'(rnd[1:0] % 2'd3), 1'b0);
        end
        drain_responses();

        cur_test = 3'd3;
        rr_vpn[0] = fresh_vpn(-1);
        drive_fill(rr_vpn[0], tlb_pkg::pte_flags_t'(8'h4F));
        drive_lookup(rr_vpn[0], tlb_pkg::acc_store, 1'b0);
        drive_lookup(rr_vpn[0], tlb_pkg::acc_load, 1'b0);
        rr_vpn[1] = fresh_vpn(-1);
        drive_fill(rr_vpn[1], tlb_pkg::pte_flags_t'(8'hC7));
        drive_lookup(rr_vpn[1], tlb_pkg::acc_fetch, 1'b0);
        rr_vpn[2] = fresh_vpn(-1);
        drive_fill(rr_vpn[2], tlb_pkg::pte_flags_t'(8'hCF));
        drive_lookup(rr_vpn[2], tlb_pkg::acc_load, 1'b1);
        rr_vpn[3] = fresh_vpn(-1);
        drive_fill(rr_vpn[3], tlb_pkg::pte_flags_t'(8'h8F));
        drive_lookup(rr_vpn[3], tlb_pkg::acc_load, 1'b0);
        rr_vpn[3] = fresh_vpn(-1);
        drive_fill(rr_vpn[3], tlb_pkg::pte_flags_t'(8'hDF));
        drive_lookup(rr_vpn[3], tlb_pkg::acc_load, 1'b1);
        drain_responses();

        // One more fill than ways into a single set
        cur_test = 3'd4;
        rnd = $random(seed);
        for (int i = 0; i <= WAYS; i++) begin
            rr_vpn[i] = fresh_vpn(int'(rnd[ENTRIES_W-1:0]));
            drive_fill(rr_vpn[i], tlb_pkg::pte_flags_t'(8'hCF));
        end
        for (int i = 0; i <= WAYS; i++) begin
            drive_lookup(rr_vpn[i], tlb_pkg::acc_load, 1'b0);
        end
        drain_responses();

        cur_test = 3'd5;
        drive_flush();
        for (int i = 0; i < filled.size(); i++) begin
            drive_lookup(filled[i], tlb_pkg::acc_load, 1'b0);
        end
        rr_vpn[0] = fresh_vpn(-1);
        drive_fill(rr_vpn[0], tlb_pkg::pte_flags_t'(8'hCF));
        drive_lookup(rr_vpn[0], tlb_pkg::acc_load, 1'b0);
        drain_responses();

        // Mix of known and random pages on consecutive cycles
        cur_test = 3'd6;
        for (int i = 0; i < 4; i++) begin
            drive_fill(fresh_vpn(-1), tlb_pkg::pte_flags_t'(8'hCF));
        end
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            if (rnd[16]) begin
                drive_lookup(filled[rnd[15:0] % filled.size()], tlb_pkg::acc_load, 1'b0);
            end else begin
                drive_lookup(fresh_vpn(-1), tlb_pkg::acc_fetch, 1'b0);
            end
        end
        drain_responses();

        $display("Responses checked %0d, value errors %0d, protocol errors %0d",
                 responses, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0 && responses > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/tlb_pkg.sv
src/tlb_mem_1rw.sv
src/tlb_assoc.sv
src/mmu_xlate.sv
src/mmu_top.sv
bench/mmu_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the Sv32 translation unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/10ps \
    --top-module mmu_top_tb \
    --Mdir obj_dir \
    -f files.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vmmu_top_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

// ==== src/mmu_top.sv ====
// Sv32 address translation unit: front end joined to the set-associative TLB
`timescale 1ns/10ps

module mmu_top #(
    parameter int ENTRIES_W = 4,
    parameter int WAYS      = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  tlb_pkg::xlate_req_t  req,
    input  logic                 fill_valid,
    input  tlb_pkg::tlb_fill_t   fill,
    input  logic                 flush,
    output logic                 resp_valid,
    output tlb_pkg::xlate_resp_t resp
);

    tlb_pkg::tlb_cmd_e         cmd;
    logic [tlb_pkg::vpn_w-1:0] vpn;
    logic [tlb_pkg::ppn_w-1:0] new_ppn;
    tlb_pkg::pte_flags_t       new_flags;
    logic                      hit;
    logic [tlb_pkg::ppn_w-1:0] hit_ppn;
    tlb_pkg::pte_flags_t       hit_flags;

    mmu_xlate u_xlate (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .fill_valid (fill_valid),
        .fill       (fill),
        .flush      (flush),
        .resp_valid (resp_valid),
        .resp       (resp),
        .cmd        (cmd),
        .vpn        (vpn),
        .new_ppn    (new_ppn),
        .new_flags  (new_flags),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .hit_flags  (hit_flags)
    );

    // Hit way is only of interest for debug
    tlb_assoc #(
        .ENTRIES_W (ENTRIES_W),
        .WAYS      (WAYS)
    ) u_tlb (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .vpn       (vpn),
        .new_ppn   (new_ppn),
        .new_flags (new_flags),
        .hit       (hit),
        .hit_ppn   (hit_ppn),
        .hit_flags (hit_flags),
        .hit_way   ()
    );

endmodule

// ==== src/mmu_xlate.sv ====
// Sv32 translation front end: issues TLB commands, checks permissions, forms the response
`timescale 1ns/10ps

module mmu_xlate (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  tlb_pkg::xlate_req_t       req,
    input  logic                      fill_valid,
    input  tlb_pkg::tlb_fill_t        fill,
    input  logic                      flush,
    output logic                      resp_valid,
    output tlb_pkg::xlate_resp_t      resp,
    output tlb_pkg::tlb_cmd_e         cmd,
    output logic [tlb_pkg::vpn_w-1:0] vpn,
    output logic [tlb_pkg::ppn_w-1:0] new_ppn,
    output tlb_pkg::pte_flags_t       new_flags,
    input  logic                      hit,
    input  logic [tlb_pkg::ppn_w-1:0] hit_ppn,
    input  tlb_pkg::pte_flags_t       hit_flags
);

    // Request context held while the TLB lookup is in flight
    logic              req_q;
    logic [11:0]       offset_q;
    tlb_pkg::access_e  access_q;
    logic              user_q;
    logic              perm_fault;

    //////////////////////////////////////////////////
    // Command encoding
    //////////////////////////////////////////////////

    // Flush beats fill beats lookup
    always_comb begin
        if (flush) begin
            cmd = tlb_pkg::cmd_invalidate_all;
        end else if (fill_valid) begin
            cmd = tlb_pkg::cmd_new_entry;
        end else if (req_valid) begin
            cmd = tlb_pkg::cmd_resolve;
        end else begin
            cmd = tlb_pkg::cmd_none;
        end
    end

    assign vpn       = fill_valid ? fill.vpn : req.vaddr[31:12];
    assign new_ppn   = fill.ppn;
    assign new_flags = fill.flags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            offset_q <= req.vaddr[11:0];
            access_q <= req.access;
            user_q   <= req.user;
        end
    end

    //////////////////////////////////////////////////
    // Permission check and response
    //////////////////////////////////////////////////

    always_comb begin
        perm_fault = !hit_flags.accessed || (hit_flags.user != user_q);
        case (access_q)
            tlb_pkg::acc_load:  perm_fault = perm_fault || !hit_flags.read;
            tlb_pkg::acc_store: perm_fault = perm_fault || !hit_flags.write || !hit_flags.dirty;
            tlb_pkg::acc_fetch: perm_fault = perm_fault || !hit_flags.execute;
            default:            perm_fault = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_q;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q) begin
            resp.hit   <= hit;
            resp.fault <= hit && perm_fault;
            resp.paddr <= (hit && !perm_fault) ? {hit_ppn, offset_q} : 34'd0;
        end
    end

    // Lookups share the command port, so they must not collide with refill or flush
    a_no_collision : assert property (
        @(posedge clk) disable iff (!rst_n) req_valid |-> !(fill_valid || flush)
    ) else $error("mmu_xlate: request in the same cycle as fill or flush");

endmodule

// ==== src/tlb_assoc.sv ====
// Set-associative TLB for 4 KiB pages with round-robin replacement
`timescale 1ns/10ps

module tlb_assoc #(
    parameter int ENTRIES_W = 4,
    parameter int WAYS      = 3
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  tlb_pkg::tlb_cmd_e                       cmd,
    input  logic [tlb_pkg::vpn_w-1:0]               vpn,
    input  logic [tlb_pkg::ppn_w-1:0]               new_ppn,
    input  tlb_pkg::pte_flags_t                     new_flags,
    output logic                                    hit,
    output logic [tlb_pkg::ppn_w-1:0]               hit_ppn,
    output tlb_pkg::pte_flags_t                     hit_flags,
    output logic [(WAYS > 1 ? $clog2(WAYS) : 1)-1:0] hit_way
);

    localparam int ENTRIES = 2 ** ENTRIES_W;
    localparam int VTAG_W  = tlb_pkg::vpn_w - ENTRIES_W;
    localparam int WAY_W   = WAYS > 1 ? $clog2(WAYS) : 1;

    typedef logic [VTAG_W-1:0]         vtag_t;
    typedef logic [tlb_pkg::ppn_w-1:0] ppn_t;
    typedef logic [6:0]                meta_t;

    // Index and tag of the incoming page number
    logic [ENTRIES_W-1:0] set_idx;
    vtag_t                vtag;

    assign set_idx = vpn[ENTRIES_W-1:0];
    assign vtag    = vpn[tlb_pkg::vpn_w-1:ENTRIES_W];

    logic                 rd;
    logic [WAYS-1:0]      we;
    logic [WAY_W-1:0]     victim;
    logic [ENTRIES-1:0]   valid [WAYS];

    vtag_t                vtag_rd [WAYS];
    ppn_t                 ppn_rd  [WAYS];
    meta_t                meta_rd [WAYS];

    // Lookup stage registers
    logic                 resolve_q;
    logic [ENTRIES_W-1:0] set_q;
    vtag_t                tag_q;
    logic [WAYS-1:0]      way_hit;

    assign rd = (cmd == tlb_pkg::cmd_resolve);

    //////////////////////////////////////////////////
    // Per-way storage
    //////////////////////////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign we[w] = (cmd == tlb_pkg::cmd_new_entry) && (victim == WAY_W'(w));

        tlb_mem_1rw #(
            .ELEMENTS_W (ENTRIES_W),
            .payload_t  (vtag_t)
        ) u_vtag (
            .clk       (clk),
            .address   (set_idx),
            .read      (rd),
            .readdata  (vtag_rd[w]),
            .write     (we[w]),
            .writedata (vtag)
        );

        tlb_mem_1rw #(
            .ELEMENTS_W (ENTRIES_W),
            .payload_t  (ppn_t)
        ) u_ppn (
            .clk       (clk),
            .address   (set_idx),
            .read      (rd),
            .readdata  (ppn_rd[w]),
            .write     (we[w]),
            .writedata (new_ppn)
        );

        // Upper seven flag bits, valid is kept in flops
        tlb_mem_1rw #(
            .ELEMENTS_W (ENTRIES_W),
            .payload_t  (meta_t)
        ) u_meta (
            .clk       (clk),
            .address   (set_idx),
            .read      (rd),
            .readdata  (meta_rd[w]),
            .write     (we[w]),
            .writedata (new_flags[7:1])
        );

        assign way_hit[w] = valid[w][set_q] && (vtag_rd[w] == tag_q);
    end

    //////////////////////////////////////////////////
    // Valid bits and victim pointer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim <= '0;
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
            end
        end else if (cmd == tlb_pkg::cmd_invalidate_all) begin
            victim <= '0;
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
            end
        end else if (cmd == tlb_pkg::cmd_new_entry) begin
            valid[victim][set_idx] <= new_flags.valid;
            // Wrap after the last way
            if (victim == WAY_W'(WAYS - 1)) begin
                victim <= '0;
            end else begin
                victim <= victim + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resolve_q <= 1'b0;
        end else begin
            resolve_q <= rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            set_q <= set_idx;
            tag_q <= vtag;
        end
    end

    // Lowest hitting way wins
    always_comb begin
        hit       = resolve_q && (|way_hit);
        hit_way   = '0;
        hit_ppn   = ppn_rd[0];
        hit_flags = tlb_pkg::pte_flags_t'({meta_rd[0], valid[0][set_q]});
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way   = WAY_W'(w);
                hit_ppn   = ppn_rd[w];
                hit_flags = tlb_pkg::pte_flags_t'({meta_rd[w], valid[w][set_q]});
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A page is never held in two ways of one set
    a_onehot_hit : assert property (
        @(posedge clk) disable iff (!rst_n) resolve_q |-> $onehot0(way_hit)
    ) else $error("tlb_assoc: more than one way hit");

    a_victim_range : assert property (
        @(posedge clk) disable iff (!rst_n) int'(victim) < WAYS
    ) else $error("tlb_assoc: victim pointer out of range");

endmodule

// ==== src/tlb_mem_1rw.sv ====
// Single-port storage array with registered read, generic over the stored payload type
`timescale 1ns/10ps

module tlb_mem_1rw #(
    parameter int ELEMENTS_W = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic                  clk,
    input  logic [ELEMENTS_W-1:0] address,
    input  logic                  read,
    output payload_t              readdata,
    input  logic                  write,
    input  payload_t              writedata
);

    localparam int ELEMENTS = 2 ** ELEMENTS_W;

    payload_t mem [ELEMENTS];

    // Write port
    always_ff @(posedge clk) begin
        if (write) begin
            mem[address] <= writedata;
        end
    end

    // Read data lands one cycle after the read strobe
    always_ff @(posedge clk) begin
        if (read) begin
            readdata <= mem[address];
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Single port, so a read and a write never share a cycle
    a_one_access : assert property (
        @(posedge clk) !(read && write)
    ) else $error("tlb_mem_1rw: read and write in the same cycle");

endmodule

// ==== src/tlb_pkg.sv ====
// Shared types for the Sv32 translation unit: TLB commands, PTE flags, request and response

package tlb_pkg;

    // Page number widths for Sv32 with 4 KiB pages
    localparam int vpn_w = 20;
    localparam int ppn_w = 22;

    // One TLB command per cycle
    typedef enum logic [1:0] {
        cmd_none           = 2'd0,
        cmd_resolve        = 2'd1,
        cmd_new_entry      = 2'd2,
        cmd_invalidate_all = 2'd3
    } tlb_cmd_e;

    // Sv32 PTE flag byte, valid is bit 0
    typedef struct packed {
        logic dirty;
        logic accessed;
        logic global_map;
        logic user;
        logic execute;
        logic write;
        logic read;
        logic valid;
    } pte_flags_t;

    typedef enum logic [1:0] {
        acc_load  = 2'd0,
        acc_store = 2'd1,
        acc_fetch = 2'd2
    } access_e;

    typedef struct packed {
        logic [31:0] vaddr;
        access_e     access;
        logic        user;
    } xlate_req_t;

    typedef struct packed {
        logic        hit;
        logic        fault;
        logic [33:0] paddr;
    } xlate_resp_t;

    typedef struct packed {
        logic [vpn_w-1:0] vpn;
        logic [ppn_w-1:0] ppn;
        pte_flags_t       flags;
    } tlb_fill_t;

endpackage
